//--- tb.f
core_pkg.sv
io_pkg.sv
rf_if.sv
program_memory.sv
register_file.sv
exec_unit.sv
core_control.sv
micro_core.sv
tb_micro_core.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator, then search the log for failure
cd "$(dirname "$0")" && rm -f sim.log \
    && verilator --binary --timing --assert --top-module tb_micro_core -f tb.f -o sim_micro_core \
    && ./obj_dir/sim_micro_core > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Finished with errors" sim.log && exit 1 || exit 0

//--- tb_micro_core.sv
/*
 * Testbench for the compute core: loads programs, preloads registers, runs
 * them and checks every readback against a reference model
 */
`timescale 1ns/1ps

module tb_micro_core import core_pkg::*, io_pkg::*; ();

    localparam int          half_period  = 20;
    localparam logic [31:0] tb_seed      = 32'hd6344a14;
    localparam int          done_timeout = 1000;
    localparam int          iterations   = 20;

    logic      clock;
    logic      arst_n;
    logic      run;
    logic      prog_write;
    pc_t       prog_address;
    word_t     prog_data;
    logic      dma_write;
    reg_addr_t dma_address;
    word_t     dma_data;
    logic      read_request;
    reg_addr_t read_address;
    logic      busy;
    logic      done;
    logic      read_valid;
    word_t     read_data;

    word_t  model_regs [num_regs];
    instr_t prog_image [prog_depth];
    int     errors;
    int     timeouts;
    int     cycle_count;
    int     run_edge;

    micro_core u_dut (
        .clock        (clock),
        .arst_n       (arst_n),
        .run          (run),
        .prog_write   (prog_write),
        .prog_address (prog_address),
        .prog_data    (prog_data),
        .dma_write    (dma_write),
        .dma_address  (dma_address),
        .dma_data     (dma_data),
        .read_request (read_request),
        .read_address (read_address),
        .busy         (busy),
        .done         (done),
        .read_valid   (read_valid),
        .read_data    (read_data)
    );

    always #half_period clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
    end

    read_latency: assert property (@(posedge clock) disable iff (!arst_n)
        read_request |=> read_valid)
    else begin
        errors++;
        $display("mismatch at %0t: read_valid missing after read_request", $time);
    end

    read_quiet: assert property (@(posedge clock) disable iff (!arst_n)
        !read_request |=> !read_valid)
    else begin
        errors++;
        $display("mismatch at %0t: read_valid without a request", $time);
    end

    // Done is a single pulse and the core is idle right after it
    done_pulse: assert property (@(posedge clock) disable iff (!arst_n)
        done |=> !done && !busy)
    else begin
        errors++;
        $display("mismatch at %0t: done longer than one cycle or busy after done", $time);
    end

    function automatic instr_t make_instr(opcode_t op, int dest, int src_a, int src_b, int imm);
        return {op, 4'(dest), 4'(src_a), 4'(src_b), 16'(imm)};
    endfunction

    // Reference model of one instruction, returns high for stop
    function automatic logic model_step(instr_t word);
        opcode_t   op;
        reg_addr_t dest;
        word_t     a;
        word_t     b;
        op   = opcode_t'(word[31:28]);
        dest = word[27:24];
        a    = model_regs[word[23:20]];
        b    = model_regs[word[19:16]];
        case (op)
            op_add:  model_regs[dest] = a + b;
            op_sub:  model_regs[dest] = a - b;
            op_mul:  model_regs[dest] = a * b;
            op_and:  model_regs[dest] = a & b;
            op_or:   model_regs[dest] = a | b;
            op_xor:  model_regs[dest] = a ^ b;
            op_shl:  model_regs[dest] = a << b[4:0];
            op_shr:  model_regs[dest] = a >> b[4:0];
            op_ldi:  model_regs[dest] = {16'h0000, word[15:0]};
            default: ;
        endcase
        return op == op_stop;
    endfunction

    // Runs the stored program from address zero, returns the instruction count
    function automatic int model_run();
        int   pc;
        int   count;
        logic stopped;
        pc      = 0;
        count   = 0;
        stopped = 1'b0;
        while (!stopped) begin
            stopped = model_step(prog_image[pc_t'(pc)]) || (pc == prog_depth - 1);
            count++;
            pc++;
        end
        return count;
    endfunction

    task automatic next_cycle();
        @(posedge clock);
        #2;
    endtask

    task automatic load_word(input int address, input instr_t word);
        prog_write   = 1'b1;
        prog_address = pc_t'(address);
        prog_data    = word;
        prog_image[pc_t'(address)] = word;
        next_cycle();
        prog_write = 1'b0;
    endtask

    task automatic preload_register(input int index, input word_t value);
        dma_write   = 1'b1;
        dma_address = reg_addr_t'(index);
        dma_data    = value;
        model_regs[reg_addr_t'(index)] = value;
        next_cycle();
        dma_write = 1'b0;
    endtask

    task automatic read_check(input int index);
        read_request = 1'b1;
        read_address = reg_addr_t'(index);
        next_cycle();
        read_request = 1'b0;
        @(negedge clock);
        assert (read_valid === 1'b1 && read_data === model_regs[reg_addr_t'(index)]) else begin
            errors++;
            $display("mismatch at %0t: register %0d read %h valid %b, expected %h",
                     $time, index, read_data, read_valid, model_regs[reg_addr_t'(index)]);
        end
        next_cycle();
    endtask

    task automatic check_all_registers();
        for (int i = 0; i < num_regs; i++) begin
            read_check(i);
        end
    endtask

    task automatic start_run();
        run = 1'b1;
        next_cycle();
        run      = 1'b0;
        run_edge = cycle_count;
    endtask

    // Busy must stay high from the cycle after run up to the done pulse
    task automatic wait_for_done(input int length);
        int waited;
        int latency;
        waited = 0;
        do begin
            @(negedge clock);
            waited++;
            assert (busy) else begin
                errors++;
                $display("mismatch at %0t: busy low while the program runs", $time);
            end
        end while (!done && waited < done_timeout);
        if (!done) begin
            timeouts++;
            $display("Timeout: done did not arrive within %0d cycles of run", done_timeout);
        end else begin
            latency = cycle_count - run_edge + 1;
            assert (latency == 3 * length) else begin
                errors++;
                $display("mismatch at %0t: done came %0d cycles after run, expected %0d",
                         $time, latency, 3 * length);
            end
        end
        next_cycle();
    endtask

    // After a run nothing may start again on its own
    task automatic check_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clock);
            assert (!done && !busy) else begin
                errors++;
                $display("mismatch at %0t: extra done or busy after the run ended", $time);
            end
        end
        next_cycle();
    endtask

    task automatic run_and_check();
        int length;
        length = model_run();
        start_run();
        wait_for_done(length);
        check_all_registers();
    endtask

    initial begin
        int length;
        void'($urandom(tb_seed));
        clock        = 1'b0;
        arst_n       = 1'b0;
        run          = 1'b0;
        prog_write   = 1'b0;
        prog_address = '0;
        prog_data    = '0;
        dma_write    = 1'b0;
        dma_address  = '0;
        dma_data     = '0;
        read_request = 1'b0;
        read_address = '0;
        errors       = 0;
        timeouts     = 0;
        cycle_count  = 0;
        for (int i = 0; i < num_regs; i++) begin
            model_regs[i] = '0;
        end

        repeat (5) begin
            next_cycle();
            assert (!busy && !done && !read_valid) else begin
                errors++;
                $display("mismatch at %0t: busy, done or read_valid high in reset", $time);
            end
        end
        arst_n = 1'b1;
        next_cycle();
        check_all_registers();

        for (int i = 0; i < num_regs; i++) begin
            preload_register(i, $urandom);
        end
        check_all_registers();

        // Two operands in r2 and r3, results in r4 to r6
        load_word(0, make_instr(op_add, 4, 2, 3, 0));
        load_word(1, make_instr(op_sub, 5, 2, 3, 0));
        load_word(2, make_instr(op_mul, 6, 2, 3, 0));
        load_word(3, make_instr(op_stop, 0, 0, 0, 0));
        for (int it = 0; it < iterations; it++) begin
            preload_register(2, $urandom);
            preload_register(3, $urandom);
            run_and_check();
        end

        load_word(0, make_instr(op_ldi, 1, 0, 0, 'ha5c3));
        load_word(1, make_instr(op_and, 10, 1, 7, 0));
        load_word(2, make_instr(op_or, 11, 1, 7, 0));
        load_word(3, make_instr(op_xor, 12, 7, 1, 0));
        load_word(4, make_instr(op_shl, 13, 7, 8, 0));
        load_word(5, make_instr(op_shr, 14, 7, 9, 0));
        load_word(6, make_instr(op_stop, 0, 0, 0, 0));
        for (int it = 0; it < 3; it++) begin
            preload_register(7, $urandom);
            preload_register(8, $urandom | 32'h20);
            preload_register(9, 31 + it);
            run_and_check();
        end

        // Preload and a second run arrive while the program is running
        preload_register(3, $urandom);
        length = model_run();
        start_run();
        repeat (3) next_cycle();
        dma_write   = 1'b1;
        dma_address = 4'd3;
        dma_data    = ~model_regs[3];
        run         = 1'b1;
        next_cycle();
        dma_write = 1'b0;
        run       = 1'b0;
        wait_for_done(length);
        check_quiet(3 * length + 3);
        check_all_registers();

        // No stop anywhere, so the run ends when the counter wraps
        for (int a = 0; a < prog_depth; a++) begin
            if (a % 3 == 2) begin
                load_word(a, make_instr(op_add, a % 16, (a + 1) % 16, (a + 5) % 16, 0));
            end else begin
                load_word(a, make_instr(op_ldi, a % 16, 0, 0, (a * 'h0101) ^ 'h5a3c));
            end
        end
        run_and_check();
        check_quiet(16);

        $display("Closing counts: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- micro_core.sv
/*
 * Top level of the compute core, joining program memory, register file,
 * execution unit and controller behind plain host ports
 */
`timescale 1ns/1ps

module micro_core import core_pkg::*, io_pkg::*; (
    input  logic      clock,
    input  logic      arst_n,
    input  logic      run,
    input  logic      prog_write,
    input  pc_t       prog_address,
    input  word_t     prog_data,
    input  logic      dma_write,
    input  reg_addr_t dma_address,
    input  word_t     dma_data,
    input  logic      read_request,
    input  reg_addr_t read_address,
    output logic      busy,
    output logic      done,
    output logic      read_valid,
    output word_t     read_data
);

    pc_t     fetch_address;
    instr_t  instruction;
    opcode_t opcode;
    imm_t    immediate;

    rf_if u_rf_if ();

    program_memory u_program_memory (
        .clock         (clock),
        .prog_write    (prog_write),
        .prog_address  (prog_address),
        .prog_data     (prog_data),
        .fetch_address (fetch_address),
        .instruction   (instruction)
    );

    register_file u_register_file (
        .clock        (clock),
        .arst_n       (arst_n),
        .rf           (u_rf_if),
        .dma_write    (dma_write),
        .dma_address  (dma_address),
        .dma_data     (dma_data),
        .read_request (read_request),
        .read_address (read_address),
        .read_valid   (read_valid),
        .read_data    (read_data)
    );

    exec_unit u_exec_unit (
        .exu       (u_rf_if),
        .opcode    (opcode),
        .immediate (immediate)
    );

    core_control u_core_control (
        .clock         (clock),
        .arst_n        (arst_n),
        .run           (run),
        .done          (done),
        .ctrl          (u_rf_if),
        .fetch_address (fetch_address),
        .instruction   (instruction),
        .opcode        (opcode),
        .immediate     (immediate)
    );

    // The controller owns busy and the register file already sees it
    assign busy = u_rf_if.busy;

endmodule

//--- core_control.sv
/*
 * Core controller with the program counter and the idle, fetch, decode and
 * execute sequence, three cycles per instruction until stop or a wrap
 */
`timescale 1ns/1ps

module core_control import core_pkg::*, io_pkg::*; (
    input  logic    clock,
    input  logic    arst_n,
    input  logic    run,
    output logic    done,
    rf_if.ctrl      ctrl,
    output pc_t     fetch_address,
    input  instr_t  instruction,
    output opcode_t opcode,
    output imm_t    immediate
);

    typedef enum logic [1:0] {
        st_idle,
        st_fetch,
        st_decode,
        st_execute
    } core_state_t;

    core_state_t state;
    pc_t         pc;
    opcode_t     op_q;
    reg_addr_t   dest_q;
    reg_addr_t   src_a_q;
    reg_addr_t   src_b_q;
    imm_t        imm_q;
    logic        writes_result;
    logic        last_step;

    // Sequencer and program counter
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
            pc    <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (run) begin
                        state <= st_fetch;
                        pc    <= '0;
                    end
                end
                st_fetch: begin
                    state <= st_decode;
                end
                st_decode: begin
                    state <= st_execute;
                end
                st_execute: begin
                    pc    <= pc + pc_t'(1);
                    state <= last_step ? st_idle : st_fetch;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // The opcode decides on core writes, so it starts from a harmless value
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            op_q <= op_nop;
        end else if (state == st_decode) begin
            op_q <= opcode_t'(instruction[opcode_lsb +: opcode_width]);
        end
    end

    always_ff @(posedge clock) begin
        if (state == st_decode) begin
            dest_q  <= instruction[dest_lsb +: reg_addr_width];
            src_a_q <= instruction[src_a_lsb +: reg_addr_width];
            src_b_q <= instruction[src_b_lsb +: reg_addr_width];
            imm_q   <= instruction[imm_lsb +: imm_width];
        end
    end

    always_comb begin
        case (op_q)
            op_add, op_sub, op_mul, op_and, op_or, op_xor, op_shl, op_shr, op_ldi: begin
                writes_result = 1'b1;
            end
            default: begin
                writes_result = 1'b0;
            end
        endcase
    end

    // A run ends on stop or when the counter is about to wrap past the top
    assign last_step = (op_q == op_stop) || (pc == last_pc);

    assign done               = (state == st_execute) && last_step;
    assign fetch_address      = pc;
    assign opcode             = op_q;
    assign immediate          = imm_q;
    assign ctrl.read_addr_a   = src_a_q;
    assign ctrl.read_addr_b   = src_b_q;
    assign ctrl.write_address = dest_q;
    assign ctrl.write_enable  = (state == st_execute) && writes_result;
    assign ctrl.busy          = (state != st_idle);

endmodule

//--- exec_unit.sv
/*
 * Integer execution unit, purely combinational, computing one result per
 * opcode from the two register operands or the immediate
 */
`timescale 1ns/1ps

module exec_unit import core_pkg::*; (
    rf_if.exu         exu,
    input  opcode_t   opcode,
    input  imm_t      immediate
);

    shamt_t shift_amount;
    word_t  imm_word;
    word_t  product;

    // Shift amounts of 32 and above fold back onto their low five bits
    assign shift_amount = exu.operand_b[shamt_width-1:0];

    // The immediate is zero extended to a full word
    assign imm_word = {{(word_width - imm_width){1'b0}}, immediate};

    // Only the low word of the product is kept
    assign product = exu.operand_a * exu.operand_b;

    always_comb begin
        case (opcode)
            op_add: begin
                exu.result = exu.operand_a + exu.operand_b;
            end
            op_sub: begin
                exu.result = exu.operand_a - exu.operand_b;
            end
            op_mul: begin
                exu.result = product;
            end
            op_and: begin
                exu.result = exu.operand_a & exu.operand_b;
            end
            op_or: begin
                exu.result = exu.operand_a | exu.operand_b;
            end
            op_xor: begin
                exu.result = exu.operand_a ^ exu.operand_b;
            end
            op_shl: begin
                exu.result = exu.operand_a << shift_amount;
            end
            op_shr: begin
                exu.result = exu.operand_a >> shift_amount;
            end
            op_ldi: begin
                exu.result = imm_word;
            end
            // nop, stop and unused codes produce zero and are never written
            default: begin
                exu.result = '0;
            end
        endcase
    end

endmodule

//--- register_file.sv
/*
 * Register file of sixteen 32-bit registers with two combinational read
 * ports, a core write port, a host preload port and a host readback port
 */
`timescale 1ns/1ps

module register_file import core_pkg::*; (
    input  logic      clock,
    input  logic      arst_n,
    rf_if.rf          rf,
    input  logic      dma_write,
    input  reg_addr_t dma_address,
    input  word_t     dma_data,
    input  logic      read_request,
    input  reg_addr_t read_address,
    output logic      read_valid,
    output word_t     read_data
);

    word_t regs [num_regs];
    logic  preload;

    // The host may only preload while the core is idle
    assign preload = dma_write && !rf.busy;

    // Core writes happen only in execute, so they never meet a preload
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (rf.write_enable) begin
            regs[rf.write_address] <= rf.result;
        end else if (preload) begin
            regs[dma_address] <= dma_data;
        end
    end

    assign rf.operand_a = regs[rf.read_addr_a];
    assign rf.operand_b = regs[rf.read_addr_b];

    // Readback answers one cycle after the request, in any core state
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            read_valid <= 1'b0;
        end else begin
            read_valid <= read_request;
        end
    end

    always_ff @(posedge clock) begin
        if (read_request) begin
            read_data <= regs[read_address];
        end
    end

endmodule

//--- program_memory.sv
/*
 * Program memory with a host write port and a registered fetch port
 */
`timescale 1ns/1ps

module program_memory import core_pkg::*, io_pkg::*; (
    input  logic   clock,
    input  logic   prog_write,
    input  pc_t    prog_address,
    input  word_t  prog_data,
    input  pc_t    fetch_address,
    output instr_t instruction
);

    word_t mem [prog_depth];

    // Host side, one word per strobe
    always_ff @(posedge clock) begin
        if (prog_write) begin
            mem[prog_address] <= prog_data;
        end
    end

    // The fetch port samples every cycle, so the word appears one cycle
    // after its address and stays while the address is held
    always_ff @(posedge clock) begin
        instruction <= instr_t'(mem[fetch_address]);
    end

endmodule

//--- rf_if.sv
/*
 * Register file access bundle shared by the controller, the register file
 * and the execution unit
 */
`timescale 1ns/1ps

interface rf_if import core_pkg::*; ();

    reg_addr_t read_addr_a;
    reg_addr_t read_addr_b;
    logic      write_enable;
    reg_addr_t write_address;
    logic      busy;
    word_t     operand_a;
    word_t     operand_b;
    word_t     result;

    modport ctrl (
        output read_addr_a,
        output read_addr_b,
        output write_enable,
        output write_address,
        output busy
    );

    modport rf (
        input  read_addr_a,
        input  read_addr_b,
        input  write_enable,
        input  write_address,
        input  busy,
        input  result,
        output operand_a,
        output operand_b
    );

    modport exu (
        input  operand_a,
        input  operand_b,
        output result
    );

endinterface

//--- io_pkg.sv
/*
 * Host port definitions: program address type and program memory size
 */
package io_pkg;

    localparam int pc_width   = 6;
    localparam int prog_depth = 64;

    typedef logic [pc_width-1:0] pc_t;

    // Executing this address without a stop wraps the program counter
    localparam pc_t last_pc = pc_t'(prog_depth - 1);

endpackage

//--- core_pkg.sv
/*
 * Core definitions for the integer compute core: data word, register index,
 * instruction layout and opcode encoding
 */
package core_pkg;

    localparam int word_width     = 32;
    localparam int reg_addr_width = 4;
    localparam int num_regs       = 16;
    localparam int imm_width      = 16;
    localparam int opcode_width   = 4;

    // Only the low five bits of operand b count as a shift amount
    localparam int shamt_width    = 5;

    // Field positions inside an instruction word, counted from bit zero
    localparam int opcode_lsb = 28;
    localparam int dest_lsb   = 24;
    localparam int src_a_lsb  = 20;
    localparam int src_b_lsb  = 16;
    localparam int imm_lsb    = 0;

    typedef logic [word_width-1:0]     word_t;
    typedef logic [reg_addr_width-1:0] reg_addr_t;
    typedef logic [imm_width-1:0]      imm_t;
    typedef logic [shamt_width-1:0]    shamt_t;

    // Opcode, destination, source a, source b, immediate from the top bit down
    typedef logic [word_width-1:0]     instr_t;

    typedef enum logic [opcode_width-1:0] {
        op_nop  = 4'h0,
        op_add  = 4'h1,
        op_sub  = 4'h2,
        op_mul  = 4'h3,
        op_and  = 4'h4,
        op_or   = 4'h5,
        op_xor  = 4'h6,
        op_shl  = 4'h7,
        op_shr  = 4'h8,
        op_ldi  = 4'h9,
        op_stop = 4'hf
    } opcode_t;

endpackage
